// ==== files.f ====
common/ecc_pkg.sv
rtl/ecc_74_codec.sv
ecc_bank/ecc_bank.sv
rtl/axil_cmd_regs.sv
rtl/ecc_result_drain.sv
rtl/ecc_store_top.sv
tests/tb_clock_gen.sv
tests/ecc_store_properties.sv
tests/tb_ecc_store.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_ecc_store
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

# Exit status of the simulation is the test result
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// ==== tests/tb_ecc_store.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_ecc_store;
    import ecc_pkg::*;

    localparam int CLK_PERIOD_NS = 4;
    localparam int RESET_CYCLES  = 16;
    localparam int TXN_COUNT     = 283; // AXI transactions over all tests
    localparam int WATCHDOG_NS   = (RESET_CYCLES + 60 * TXN_COUNT) * CLK_PERIOD_NS;

    logic       clk;
    logic       rst;
    axil_addr_t awaddr;
    logic       awvalid;
    logic       awready;
    axil_data_t wdata;
    logic [3:0] wstrb;
    logic       wvalid;
    logic       wready;
    logic [1:0] bresp;
    logic       bvalid;
    logic       bready;
    axil_addr_t araddr;
    logic       arvalid;
    logic       arready;
    axil_data_t rdata;
    logic [1:0] rresp;
    logic       rvalid;
    logic       rready;

    err_count_t exp_sbit_count;
    err_count_t exp_dbit_count;

    tb_clock_gen u_tb_clock_gen (
        .clk (clk)
    );

    ecc_store_top u_ecc_store_top (
        .clk     (clk),
        .rst     (rst),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready)
    );

    // ************************************************************************
    // Failure and compare tasks
    // ************************************************************************
    task automatic abort_run(input string line);
        $display("%s", line);
        $display("Testbench failed");
        $fatal(1, "Run stopped at first error");
    endtask

    task automatic check_data(input data_t got, input data_t exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("ERR %0t: %s data %h, expected %h", $time, what, got, exp));
        end
    endtask

    task automatic check_flags(input logic got_s, input logic got_d,
                               input logic exp_s, input logic exp_d, input string what);
        if ({got_s, got_d} !== {exp_s, exp_d}) begin
            abort_run($sformatf("ERR %0t: %s flags sbit %b dbit %b, expected %b %b",
                                $time, what, got_s, got_d, exp_s, exp_d));
        end
    endtask

    task automatic check_count(input err_count_t got, input err_count_t exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("ERR %0t: %s count %0d, expected %0d", $time, what, got, exp));
        end
    endtask

    task automatic check_resp(input logic [1:0] got, input string what);
        if (got !== 2'b00) begin
            abort_run($sformatf("ERR %0t: %s response %b, expected OKAY", $time, what, got));
        end
    endtask

    // ************************************************************************
    // AXI4-Lite tasks driven 1 ns after the edge and sampled at the falling edge
    // ************************************************************************

    // Random back-pressure on the response channels
    task automatic random_stall();
        int unsigned cycles;
        cycles = $urandom_range(0, 2);
        repeat (cycles) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic axil_write(input axil_addr_t addr, input axil_data_t data);
        @(posedge clk);
        #1;
        awaddr  = addr;
        awvalid = 1'b1;
        wdata   = data;
        wvalid  = 1'b1;
        @(negedge clk);
        while (!(awready && wready)) @(negedge clk);
        @(posedge clk);
        #1;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        random_stall();
        bready  = 1'b1;
        @(negedge clk);
        while (!bvalid) @(negedge clk);
        check_resp(bresp, "write");
        @(posedge clk);
        #1;
        bready = 1'b0;
    endtask

    task automatic axil_read(input axil_addr_t addr, output axil_data_t data);
        @(posedge clk);
        #1;
        araddr  = addr;
        arvalid = 1'b1;
        @(negedge clk);
        while (!arready) @(negedge clk);
        @(posedge clk);
        #1;
        arvalid = 1'b0;
        random_stall();
        rready  = 1'b1;
        @(negedge clk);
        while (!rvalid) @(negedge clk);
        check_resp(rresp, "read");
        data = rdata;
        @(posedge clk);
        #1;
        rready = 1'b0;
    endtask

    function automatic axil_data_t cmd_word(input logic write, input bank_sel_t bank,
                                           input entry_t entry);
        return {23'd0, write, 2'd0, bank, entry};
    endfunction

    function automatic axil_data_t ctrl_word(input logic bypass, input logic a_en,
                                            input bit_pos_t a_pos, input logic b_en,
                                            input bit_pos_t b_pos);
        return {8'd0, b_en, b_pos, a_en, a_pos, 7'd0, bypass};
    endfunction

    function automatic data_t random_word();
        data_t w;
        w[31:0]  = $urandom();
        w[63:32] = $urandom();
        w[73:64] = 10'($urandom());
        return w;
    endfunction

    // ************************************************************************
    // Word tasks
    // ************************************************************************
    task automatic store_word(input bank_sel_t bank, input entry_t entry, input data_t data);
        axil_write(ADDR_WDATA0, data[31:0]);
        axil_write(ADDR_WDATA1, data[63:32]);
        axil_write(ADDR_WDATA2, {22'd0, data[73:64]});
        axil_write(ADDR_CMD, cmd_word(1'b1, bank, entry));
    endtask

    task automatic load_word(input bank_sel_t bank, input entry_t entry,
                             output data_t data, output logic sbit, output logic dbit);
        axil_data_t word0;
        axil_data_t word1;
        axil_data_t word2;
        axil_data_t status;
        axil_write(ADDR_CMD, cmd_word(1'b0, bank, entry));
        axil_read(ADDR_RDATA0, word0);
        axil_read(ADDR_RDATA1, word1);
        axil_read(ADDR_RDATA2, word2);
        axil_read(ADDR_STATUS, status);
        data = {word2[9:0], word1, word0};
        sbit = status[0];
        dbit = status[1];
    endtask

    task automatic verify_entry(input bank_sel_t bank, input entry_t entry, input data_t exp,
                                input logic exp_s, input logic exp_d, input string what);
        data_t got;
        logic  got_s;
        logic  got_d;
        load_word(bank, entry, got, got_s, got_d);
        check_data(got, exp, what);
        check_flags(got_s, got_d, exp_s, exp_d, what);
        if (exp_s) exp_sbit_count = exp_sbit_count + 1'b1;
        if (exp_d) exp_dbit_count = exp_dbit_count + 1'b1;
    endtask

    task automatic expect_counts(input string what);
        axil_data_t status;
        axil_read(ADDR_STATUS, status);
        check_count(status[15:8], exp_sbit_count, {what, " single"});
        check_count(status[23:16], exp_dbit_count, {what, " double"});
    endtask

    // ************************************************************************
    // Directed tests
    // ************************************************************************
    task automatic clean_word_readback();
        data_t  words [NUM_BANKS][3];
        entry_t entries [3] = '{4'd0, 4'd9, 4'd15};
        for (int b = 0; b < NUM_BANKS; b++) begin
            for (int k = 0; k < 3; k++) begin
                words[b][k] = random_word();
                store_word(bank_sel_t'(b), entries[k], words[b][k]);
            end
        end
        // Reads start after all stores so a stray write shows up
        for (int b = 0; b < NUM_BANKS; b++) begin
            for (int k = 0; k < 3; k++) begin
                verify_entry(bank_sel_t'(b), entries[k], words[b][k], 1'b0, 1'b0,
                             $sformatf("clean bank %0d entry %0d", b, entries[k]));
            end
        end
        expect_counts("after clean reads");
    endtask

    task automatic single_flip_correct(input logic in_parity);
        data_t    word;
        bit_pos_t pos;
        for (int i = 0; i < NUM_BANKS; i++) begin
            word = random_word();
            if (in_parity) begin
                pos = 7'(DATA_WIDTH + $urandom_range(0, PARITY_WIDTH - 1));
                set_ctrl(ctrl_word(1'b0, 1'b0, '0, 1'b1, pos)); // Via position B
            end else begin
                pos = 7'($urandom_range(0, DATA_WIDTH - 1));
                set_ctrl(ctrl_word(1'b0, 1'b1, pos, 1'b0, '0));
            end
            store_word(bank_sel_t'(i), 4'd3, word);
            set_ctrl('0);
            verify_entry(bank_sel_t'(i), 4'd3, word, 1'b1, 1'b0,
                         $sformatf("single flip at %0d", pos));
        end
        expect_counts("after single flips");
    endtask

    task automatic double_flip_detect();
        data_t     word;
        bit_pos_t  pos_a;
        bit_pos_t  pos_b;
        codeword_t flips;
        for (int i = 0; i < NUM_BANKS; i++) begin
            word  = random_word();
            pos_a = 7'($urandom_range(0, CODE_WIDTH - 1));
            do begin
                pos_b = 7'($urandom_range(0, CODE_WIDTH - 1));
            end while (pos_b == pos_a);
            flips        = '0;
            flips[pos_a] = 1'b1;
            flips[pos_b] = 1'b1;
            set_ctrl(ctrl_word(1'b0, 1'b1, pos_a, 1'b1, pos_b));
            store_word(bank_sel_t'(i), 4'd6, word);
            set_ctrl('0);
            verify_entry(bank_sel_t'(i), 4'd6, word ^ flips[DATA_WIDTH-1:0], 1'b0, 1'b1,
                         $sformatf("double flip at %0d and %0d", pos_a, pos_b));
        end
        expect_counts("after double flips");
    endtask

    task automatic bypass_readback();
        data_t    word;
        bit_pos_t pos;
        for (int i = 0; i < 2; i++) begin
            word = random_word();
            pos  = 7'($urandom_range(0, DATA_WIDTH - 1));
            set_ctrl(ctrl_word(1'b0, 1'b1, pos, 1'b0, '0));
            store_word(bank_sel_t'(i + 2), 4'd12, word);
            set_ctrl(ctrl_word(1'b1, 1'b0, '0, 1'b0, '0));
            verify_entry(bank_sel_t'(i + 2), 4'd12, word ^ (data_t'(1) << pos), 1'b0, 1'b0,
                         $sformatf("bypass with flip at %0d", pos));
            set_ctrl('0);
        end
        expect_counts("after bypass reads"); // Raw reads leave counters alone
    endtask

    task automatic counter_clear_recount();
        data_t word;
        axil_write(ADDR_STATUS, '0);
        exp_sbit_count = '0;
        exp_dbit_count = '0;
        expect_counts("after clear");
        word = random_word();
        set_ctrl(ctrl_word(1'b0, 1'b1, 7'd40, 1'b0, '0));
        store_word(2'd1, 4'd11, word);
        set_ctrl('0);
        verify_entry(2'd1, 4'd11, word, 1'b1, 1'b0, "single flip after clear");
        expect_counts("after clear and one single error");
    endtask

    task automatic set_ctrl(input axil_data_t value);
        axil_write(ADDR_CTRL, value);
    endtask

    initial begin
        void'($urandom(4710));
        rst            = 1'b1;
        awaddr         = '0;
        awvalid        = 1'b0;
        wdata          = '0;
        wstrb          = 4'hF;
        wvalid         = 1'b0;
        bready         = 1'b0;
        araddr         = '0;
        arvalid        = 1'b0;
        rready         = 1'b0;
        exp_sbit_count = '0;
        exp_dbit_count = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;

        clean_word_readback();
        single_flip_correct(1'b0);
        single_flip_correct(1'b1);
        double_flip_detect();
        bypass_readback();
        counter_clear_recount();

        $display("Testbench passed");
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        abort_run("Timeout: the tests did not finish within the allowed time");
    end

endmodule

`default_nettype wire

// ==== tests/ecc_store_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module ecc_store_properties (
    input logic                          clk,
    input logic                          rst,
    input logic                          bvalid,
    input logic                          bready,
    input logic                          rvalid,
    input logic                          rready,
    input logic [ecc_pkg::NUM_BANKS-1:0] bank_valid,
    input logic                          last_sbit,
    input logic                          last_dbit
);

    a_bvalid_hold: assert property (@(posedge clk) disable iff (rst)
        (bvalid && !bready) |=> bvalid)
        else $error("bvalid dropped before bready");

    a_rvalid_hold: assert property (@(posedge clk) disable iff (rst)
        (rvalid && !rready) |=> rvalid)
        else $error("rvalid dropped before rready");

    a_bank_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(bank_valid))
        else $error("more than one bank selected");

    a_flags_excl: assert property (@(posedge clk) disable iff (rst) !(last_sbit && last_dbit))
        else $error("single and double error flags both set");

endmodule

bind ecc_store_top ecc_store_properties u_ecc_store_properties (
    .clk        (clk),
    .rst        (rst),
    .bvalid     (bvalid),
    .bready     (bready),
    .rvalid     (rvalid),
    .rready     (rready),
    .bank_valid (bank_valid),
    .last_sbit  (last_sbit),
    .last_dbit  (last_dbit)
);

`default_nettype wire

// ==== tests/tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always #2 clk = ~clk; // 4 ns period

endmodule

`default_nettype wire

// ==== rtl/ecc_store_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module ecc_store_top (
    input  logic                clk,
    input  logic                rst,
    input  ecc_pkg::axil_addr_t awaddr,
    input  logic                awvalid,
    output logic                awready,
    input  ecc_pkg::axil_data_t wdata,
    input  logic [3:0]          wstrb,
    input  logic                wvalid,
    output logic                wready,
    output logic [1:0]          bresp,
    output logic                bvalid,
    input  logic                bready,
    input  ecc_pkg::axil_addr_t araddr,
    input  logic                arvalid,
    output logic                arready,
    output ecc_pkg::axil_data_t rdata,
    output logic [1:0]          rresp,
    output logic                rvalid,
    input  logic                rready
);
    import ecc_pkg::*;

    bank_req_t            bank_req;
    logic [NUM_BANKS-1:0] bank_valid;
    bank_rsp_t            bank_rsp [NUM_BANKS];
    logic                 bypass;
    logic                 count_clear;
    data_t                last_data;
    logic                 last_sbit;
    logic                 last_dbit;
    err_count_t           sbit_count;
    err_count_t           dbit_count;

    axil_cmd_regs u_axil_cmd_regs (
        .clk         (clk),
        .rst         (rst),
        .awaddr      (awaddr),
        .awvalid     (awvalid),
        .awready     (awready),
        .wdata       (wdata),
        .wstrb       (wstrb),
        .wvalid      (wvalid),
        .wready      (wready),
        .bresp       (bresp),
        .bvalid      (bvalid),
        .bready      (bready),
        .araddr      (araddr),
        .arvalid     (arvalid),
        .arready     (arready),
        .rdata       (rdata),
        .rresp       (rresp),
        .rvalid      (rvalid),
        .rready      (rready),
        .bank_req    (bank_req),
        .bank_valid  (bank_valid),
        .bypass      (bypass),
        .count_clear (count_clear),
        .last_data   (last_data),
        .last_sbit   (last_sbit),
        .last_dbit   (last_dbit),
        .sbit_count  (sbit_count),
        .dbit_count  (dbit_count)
    );

    // Request is broadcast, bank_valid picks the bank
    for (genvar g = 0; g < NUM_BANKS; g++) begin : g_bank
        ecc_bank u_ecc_bank (
            .clk       (clk),
            .rst       (rst),
            .req       (bank_req),
            .req_valid (bank_valid[g]),
            .rsp       (bank_rsp[g]),
            .bypass    (bypass)
        );
    end

    ecc_result_drain u_ecc_result_drain (
        .clk         (clk),
        .rst         (rst),
        .rsp         (bank_rsp),
        .count_clear (count_clear),
        .last_data   (last_data),
        .last_sbit   (last_sbit),
        .last_dbit   (last_dbit),
        .sbit_count  (sbit_count),
        .dbit_count  (dbit_count)
    );

endmodule

`default_nettype wire

// ==== rtl/ecc_result_drain.sv ====
`timescale 1ns/1ps
`default_nettype none

module ecc_result_drain (
    input  logic                clk,
    input  logic                rst,
    input  ecc_pkg::bank_rsp_t  rsp [ecc_pkg::NUM_BANKS],
    input  logic                count_clear,
    output ecc_pkg::data_t      last_data,
    output logic                last_sbit,
    output logic                last_dbit,
    output ecc_pkg::err_count_t sbit_count,
    output ecc_pkg::err_count_t dbit_count
);
    import ecc_pkg::*;

    bank_rsp_t sel;

    // At most one bank answers per cycle
    always_comb begin
        sel = '0;
        for (int i = 0; i < NUM_BANKS; i++) begin
            if (rsp[i].valid) begin
                sel = sel | rsp[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sel.valid) begin
            last_data <= sel.data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            last_sbit <= 1'b0;
            last_dbit <= 1'b0;
        end else if (sel.valid) begin
            last_sbit <= sel.sbit_err;
            last_dbit <= sel.dbit_err;
        end
    end

    // ************************************************************************
    // Saturating error counters, clear wins
    // ************************************************************************
    always_ff @(posedge clk) begin
        if (rst || count_clear) begin
            sbit_count <= '0;
            dbit_count <= '0;
        end else if (sel.valid) begin
            if (sel.sbit_err && (sbit_count != '1)) sbit_count <= sbit_count + 1'b1;
            if (sel.dbit_err && (dbit_count != '1)) dbit_count <= dbit_count + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/axil_cmd_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module axil_cmd_regs (
    input  logic                          clk,
    input  logic                          rst,
    input  ecc_pkg::axil_addr_t           awaddr,
    input  logic                          awvalid,
    output logic                          awready,
    input  ecc_pkg::axil_data_t           wdata,
    input  logic [3:0]                    wstrb,
    input  logic                          wvalid,
    output logic                          wready,
    output logic [1:0]                    bresp,
    output logic                          bvalid,
    input  logic                          bready,
    input  ecc_pkg::axil_addr_t           araddr,
    input  logic                          arvalid,
    output logic                          arready,
    output ecc_pkg::axil_data_t           rdata,
    output logic [1:0]                    rresp,
    output logic                          rvalid,
    input  logic                          rready,
    output ecc_pkg::bank_req_t            bank_req,
    output logic [ecc_pkg::NUM_BANKS-1:0] bank_valid,
    output logic                          bypass,
    output logic                          count_clear,
    input  ecc_pkg::data_t                last_data,
    input  logic                          last_sbit,
    input  logic                          last_dbit,
    input  ecc_pkg::err_count_t           sbit_count,
    input  ecc_pkg::err_count_t           dbit_count
);
    import ecc_pkg::*;

    typedef enum logic {WR_IDLE, WR_RESP} wr_state_t;
    typedef enum logic {RD_IDLE, RD_RESP} rd_state_t;

    wr_state_t wr_state;
    rd_state_t rd_state;
    logic      wr_accept;
    logic      rd_accept;
    logic      cmd_issue;
    bank_sel_t cmd_bank;
    data_t     stage_data;
    logic      flip_a_en;
    bit_pos_t  flip_a_pos;
    logic      flip_b_en;
    bit_pos_t  flip_b_pos;
    codeword_t flip_mask;

    // ************************************************************************
    // Write channel, AW and W taken together
    // ************************************************************************
    assign awready   = (wr_state == WR_IDLE) && !(awvalid && !wvalid); // Wait for W
    assign wready    = (wr_state == WR_IDLE) && !(wvalid && !awvalid); // Wait for AW
    assign wr_accept = (wr_state == WR_IDLE) && awvalid && wvalid;
    assign bvalid    = (wr_state == WR_RESP);
    assign bresp     = 2'b00;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_state <= WR_IDLE;
        end else begin
            case (wr_state)
                WR_IDLE: if (wr_accept) wr_state <= WR_RESP;
                WR_RESP: if (bready) wr_state <= WR_IDLE;
                default: wr_state <= WR_IDLE;
            endcase
        end
    end

    // Full-word writes, strobes unused
    always_ff @(posedge clk) begin
        if (wr_accept) begin
            case (awaddr)
                ADDR_WDATA0: stage_data[31:0]            <= wdata;
                ADDR_WDATA1: stage_data[63:32]           <= wdata;
                ADDR_WDATA2: stage_data[DATA_WIDTH-1:64] <= wdata[DATA_WIDTH-65:0];
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            bypass     <= 1'b0;
            flip_a_en  <= 1'b0;
            flip_a_pos <= '0;
            flip_b_en  <= 1'b0;
            flip_b_pos <= '0;
        end else if (wr_accept && (awaddr == ADDR_CTRL)) begin
            bypass     <= wdata[0];
            flip_a_pos <= wdata[14:8];
            flip_a_en  <= wdata[15];
            flip_b_pos <= wdata[22:16];
            flip_b_en  <= wdata[23];
        end
    end

    // ************************************************************************
    // Command decode
    // ************************************************************************
    assign cmd_issue   = wr_accept && (awaddr == ADDR_CMD);
    assign cmd_bank    = wdata[5:4];
    assign count_clear = wr_accept && (awaddr == ADDR_STATUS);

    always_comb begin
        flip_mask = '0;
        if (flip_a_en && (flip_a_pos < CODE_WIDTH)) flip_mask[flip_a_pos] = 1'b1;
        if (flip_b_en && (flip_b_pos < CODE_WIDTH)) flip_mask[flip_b_pos] = 1'b1;
    end

    assign bank_req.write     = wdata[8];
    assign bank_req.entry     = wdata[3:0];
    assign bank_req.data      = stage_data;
    assign bank_req.flip_mask = wdata[8] ? flip_mask : '0; // Writes only

    always_comb begin
        for (int i = 0; i < NUM_BANKS; i++) begin
            bank_valid[i] = cmd_issue && (cmd_bank == bank_sel_t'(i));
        end
    end

    // ************************************************************************
    // Read channel
    // ************************************************************************
    assign arready   = (rd_state == RD_IDLE);
    assign rd_accept = arvalid && arready;
    assign rvalid    = (rd_state == RD_RESP);
    assign rresp     = 2'b00;

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_state <= RD_IDLE;
        end else begin
            case (rd_state)
                RD_IDLE: if (rd_accept) rd_state <= RD_RESP;
                RD_RESP: if (rready) rd_state <= RD_IDLE;
                default: rd_state <= RD_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rd_accept) begin
            case (araddr)
                ADDR_WDATA0: rdata <= stage_data[31:0];
                ADDR_WDATA1: rdata <= stage_data[63:32];
                ADDR_WDATA2: rdata <= {22'd0, stage_data[DATA_WIDTH-1:64]};
                ADDR_CTRL:   rdata <= {8'd0, flip_b_en, flip_b_pos, flip_a_en, flip_a_pos,
                                       7'd0, bypass};
                ADDR_RDATA0: rdata <= last_data[31:0];
                ADDR_RDATA1: rdata <= last_data[63:32];
                ADDR_RDATA2: rdata <= {22'd0, last_data[DATA_WIDTH-1:64]};
                ADDR_STATUS: rdata <= {8'd0, dbit_count, sbit_count, 6'd0, last_dbit, last_sbit};
                default:     rdata <= '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== ecc_bank/ecc_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

module ecc_bank (
    input  logic               clk,
    input  logic               rst,
    input  ecc_pkg::bank_req_t req,
    input  logic               req_valid,
    output ecc_pkg::bank_rsp_t rsp,
    input  logic               bypass
);
    import ecc_pkg::*;

    codeword_t mem [BANK_DEPTH];
    codeword_t wr_code;
    codeword_t rd_code;
    logic      rd_valid;
    data_t     cor_data;
    logic      sbit;
    logic      dbit;

    // Encode, then inject the requested flips
    assign wr_code = {ecc_encode(req.data), req.data} ^ req.flip_mask;

    always_ff @(posedge clk) begin
        if (req_valid && req.write) begin
            mem[req.entry] <= wr_code;
        end
        if (req_valid && !req.write) begin
            rd_code <= mem[req.entry];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= req_valid && !req.write;
        end
    end

    ecc_74_codec u_codec (
        .data_in   (rd_code[DATA_WIDTH-1:0]),
        .parity_in (rd_code[CODE_WIDTH-1:DATA_WIDTH]),
        .bypass    (bypass),
        .data_out  (cor_data),
        .sbit_err  (sbit),
        .dbit_err  (dbit)
    );

    assign rsp.valid    = rd_valid;
    assign rsp.data     = cor_data;
    assign rsp.sbit_err = sbit;
    assign rsp.dbit_err = dbit;

endmodule

`default_nettype wire

// ==== rtl/ecc_74_codec.sv ====
`timescale 1ns/1ps
`default_nettype none

module ecc_74_codec (
    input  ecc_pkg::data_t   data_in,
    input  ecc_pkg::parity_t parity_in,
    input  logic             bypass,
    output ecc_pkg::data_t   data_out,
    output logic             sbit_err,
    output logic             dbit_err
);
    import ecc_pkg::*;

    parity_t syndrome;
    data_t   fix_mask;
    logic    data_hit;
    logic    parity_hit;
    logic    no_err;

    assign syndrome = parity_in ^ ecc_encode(data_in);

    // One mask bit per column that matches the syndrome
    always_comb begin
        for (int i = 0; i < DATA_WIDTH; i++) begin
            fix_mask[i] = (syndrome == CHECK_COLUMNS[i]);
        end
    end

    assign data_hit   = |fix_mask;
    assign parity_hit = $onehot(syndrome); // Error in a parity bit only
    assign no_err     = (syndrome == '0);

    // ************************************************************************
    // Output stage
    // ************************************************************************
    assign data_out = bypass ? data_in : (data_in ^ fix_mask);
    assign sbit_err = !bypass && (data_hit || parity_hit);
    assign dbit_err = !bypass && !no_err && !data_hit && !parity_hit;

endmodule

`default_nettype wire

// ==== common/ecc_pkg.sv ====
`default_nettype none

package ecc_pkg;

    // ************************************************************************
    // Sizes
    // ************************************************************************
    localparam int DATA_WIDTH     = 74;
    localparam int PARITY_WIDTH   = 8;
    localparam int CODE_WIDTH     = DATA_WIDTH + PARITY_WIDTH; // Parity in the top bits
    localparam int NUM_BANKS      = 4;
    localparam int BANK_DEPTH     = 16;
    localparam int ENTRY_WIDTH    = 4;
    localparam int BANK_SEL_WIDTH = 2;

    typedef logic [DATA_WIDTH-1:0]     data_t;
    typedef logic [PARITY_WIDTH-1:0]   parity_t;
    typedef logic [CODE_WIDTH-1:0]     codeword_t;
    typedef logic [ENTRY_WIDTH-1:0]    entry_t;
    typedef logic [BANK_SEL_WIDTH-1:0] bank_sel_t;
    typedef logic [6:0]                bit_pos_t;
    typedef logic [7:0]                err_count_t;
    typedef logic [7:0]                axil_addr_t;
    typedef logic [31:0]               axil_data_t;

    // Register map
    localparam axil_addr_t ADDR_WDATA0 = 8'h00;
    localparam axil_addr_t ADDR_WDATA1 = 8'h04;
    localparam axil_addr_t ADDR_WDATA2 = 8'h08;
    localparam axil_addr_t ADDR_CMD    = 8'h0C;
    localparam axil_addr_t ADDR_CTRL   = 8'h10;
    localparam axil_addr_t ADDR_RDATA0 = 8'h20;
    localparam axil_addr_t ADDR_RDATA1 = 8'h24;
    localparam axil_addr_t ADDR_RDATA2 = 8'h28;
    localparam axil_addr_t ADDR_STATUS = 8'h2C;

    typedef struct packed {
        logic      write;
        entry_t    entry;
        data_t     data;
        codeword_t flip_mask;
    } bank_req_t;

    typedef struct packed {
        logic  valid;
        data_t data;
        logic  sbit_err;
        logic  dbit_err;
    } bank_rsp_t;

    // ************************************************************************
    // SECDED code, one odd-weight column per data bit
    // ************************************************************************
    localparam parity_t CHECK_COLUMNS [DATA_WIDTH] = '{
        8'h83, 8'h85, 8'h86, 8'h07, 8'h89, 8'h8A, 8'h0B, 8'h8C,
        8'h0D, 8'h0E, 8'h8F, 8'h91, 8'h92, 8'h13, 8'h94, 8'h15,
        8'h16, 8'h97, 8'h98, 8'h19, 8'h1A, 8'h9B, 8'h1C, 8'h9D,
        8'h9E, 8'h1F, 8'hA1, 8'hA2, 8'h23, 8'hA4, 8'h25, 8'h26,
        8'hA7, 8'hA8, 8'h29, 8'h2A, 8'hAB, 8'h2C, 8'hAD, 8'hAE,
        8'h2F, 8'hB0, 8'h31, 8'h32, 8'hB3, 8'h34, 8'hB5, 8'hB6,
        8'h37, 8'h38, 8'hB9, 8'hBA, 8'h3B, 8'hBC, 8'h3D, 8'h3E,
        8'hBF, 8'hC1, 8'hC2, 8'h43, 8'hC4, 8'h45, 8'h46, 8'hC7,
        8'hC8, 8'h49, 8'h4A, 8'hCB, 8'h4C, 8'hCD, 8'hCE, 8'h4F,
        8'hD0, 8'h51
    };

    function automatic parity_t ecc_encode(input data_t data);
        parity_t parity;
        parity = '0;
        for (int i = 0; i < DATA_WIDTH; i++) begin
            parity = parity ^ ({PARITY_WIDTH{data[i]}} & CHECK_COLUMNS[i]);
        end
        return parity;
    endfunction

endpackage

`default_nettype wire
